/* bench/heapGolden.txt */
// command array index operand result error, all hex, one command per line
// errors 0 none 1 notAllocated 2 freed 3 outOfBounds 4 full 5 empty 6 outOfMemory
01 0 0 000 000 0 // Reset, then allocate every array
04 0 0 000 000 1
12 0 0 000 000 0
12 0 0 000 001 0
12 0 0 000 002 0
12 0 0 000 003 0
12 0 0 000 003 6
02 0 2 123 123 0 // Writes grow the size
04 0 0 000 003 0
02 0 0 abc abc 0
03 0 2 000 123 0
03 0 3 000 123 3
0f 1 0 000 123 5 // Push and pop on array 1
0e 1 0 011 123 0
0e 1 0 022 123 0
0e 1 0 033 123 0
0e 1 0 044 123 0
0e 1 0 055 123 0
0e 1 0 066 123 0
0e 1 0 077 123 0
0e 1 0 088 123 0
0e 1 0 099 123 4
0f 1 0 000 088 0
0f 1 0 000 077 0
04 1 0 000 006 0
02 2 0 7f0 7f0 0 // Arithmetic and logic on array 2 element 0
14 2 0 820 010 0
15 2 0 005 010 0
03 2 0 000 015 0
16 2 0 020 ff5 0
17 2 0 0f5 ff5 0
19 2 0 004 0f0 0
18 2 0 003 780 0
1a 2 0 000 000 0
1a 2 0 000 001 0
1b 2 0 000 ffe 0
1c 2 0 001 fff 0
1d 2 0 a5a 5a5 0
1e 2 0 3c3 181 0
03 2 0 000 181 0
14 2 1 001 181 3
13 1 0 000 181 0 // Free and reuse, last freed first
13 2 0 000 181 0
12 0 0 000 002 0
12 0 0 000 001 0
13 3 0 000 001 0
13 3 0 000 001 2
03 3 0 000 001 2
01 0 0 000 001 0
03 0 0 000 001 1
12 0 0 000 000 0
00 0 0 000 000 0 // End of list

/* bench/heapTopTb.sv */
/*
  Heap testbench: replays golden command vectors over APB into the
  heap top level and checks result, status and the command stall
*/
module heapTopTb;
  timeunit 1ns;
  timeprecision 1ps;
  import heapPkg::*;

  localparam int maxTests      = 64;    // Golden lines read at most
  localparam int fieldCount    = 6;     // Words per golden line
  localparam int timeoutCycles = 20;    // Access cycles before giving up

  logic       clock;
  logic       resetN;
  apbRequest  apb;
  apbResponse apbOut;

  apbWord golden [maxTests * fieldCount];
  int     errorCount;                   // Failed checks over the run
  logic   timedOut;                     // Some transfer never completed

  heapTop heapTop_inst (.clock, .resetN, .apb, .apbOut);

  // ----------------------------------------
  // Clock
  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;         // 100 ns period
  end

  // ----------------------------------------
  // Checks and APB access
  task automatic compareValue(input string name, input apbWord expected, input apbWord actual);
    if (expected !== actual) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  // Starts and ends 10 ns after a rising edge
  task automatic busTransfer(input logic write, input apbWord address, input apbWord data,
                             output apbWord readData, output logic slaveError,
                             output int accessCycles);
    logic done;
    done         = 1'b0;
    readData     = '0;
    slaveError   = 1'b0;
    accessCycles = 0;
    apb = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: address, pwdata: data};
    @(posedge clock);
    #10 apb.penable = 1'b1;             // Access phase
    while (!done && accessCycles < timeoutCycles) begin
      @(negedge clock);                 // Mid cycle, outputs settled
      accessCycles++;
      if (apbOut.pready) begin
        done       = 1'b1;
        readData   = apbOut.prdata;
        slaveError = apbOut.pslverr;
      end
      @(posedge clock);
      #10;
    end
    apb = '0;                           // Back to idle bus
    if (!done) begin
      $display("no pready within %0d access cycles at address %h", timeoutCycles, address);
      timedOut = 1'b1;
      errorCount++;
    end
  endtask

  task automatic apbWrite(input apbWord address, input apbWord data,
                          output logic slaveError, output int accessCycles);
    apbWord ignored;
    busTransfer(1'b1, address, data, ignored, slaveError, accessCycles);
  endtask

  task automatic apbRead(input apbWord address, output apbWord data, output int accessCycles);
    logic ignored;
    busTransfer(1'b0, address, '0, data, ignored, accessCycles);
  endtask

  // ----------------------------------------
  // Golden replay
  initial begin
    apbWord command, arrayNum, index, operand, expResult, expError;
    apbWord readValue, statusValue;
    logic   commandError, slaveError;
    int     cycles, base, testCount, failedTests, errorsBefore;
    apb         = '0;
    resetN      = 1'b0;
    errorCount  = 0;
    timedOut    = 1'b0;
    testCount   = 0;
    failedTests = 0;
    $readmemh("bench/heapGolden.txt", golden);
    repeat (5) @(posedge clock);        // Reset held 5 cycles
    #10 resetN = 1'b1;
    @(posedge clock);
    #10;
    for (int t = 0; t < maxTests; t++) begin
      base    = t * fieldCount;
      command = golden[base];
      if ($isunknown(command) || command == '0)
        break;                          // End marker
      arrayNum     = golden[base + 1];
      index        = golden[base + 2];
      operand      = golden[base + 3];
      expResult    = golden[base + 4];
      expError     = golden[base + 5];
      errorsBefore = errorCount;
      apbWrite(regSelect, (arrayNum << 8) | index, slaveError, cycles);
      compareValue("regSelect access cycles", 1, cycles);
      apbWrite(regOperand, operand, slaveError, cycles);
      compareValue("regOperand access cycles", 1, cycles);
      apbWrite(regCommand, command, commandError, cycles);
      compareValue("regCommand access cycles", 3, cycles);  // Fetch, execute, respond
      compareValue("pslverr", apbWord'(expError != '0), apbWord'(commandError));
      apbRead(regResult, readValue, cycles);
      compareValue("regResult access cycles", 1, cycles);
      compareValue("regResult", expResult, readValue);
      apbRead(regStatus, statusValue, cycles);
      compareValue("regStatus", expError, statusValue);       // Busy bit clear too
      compareValue("pslverr against regStatus", apbWord'(statusValue[3:0] != 4'h0),
                   apbWord'(commandError));
      testCount++;
      if (errorCount == errorsBefore) begin
        $display("test %0d command %h array %0d index %0d ok",
                 t, command[7:0], arrayNum, index);
      end else begin
        failedTests++;
        $display("test %0d command %h array %0d index %0d failed",
                 t, command[7:0], arrayNum, index);
      end
      if (timedOut)
        break;                          // Bus is stuck, stop replaying
    end
    if (testCount == 0)
      $display("no vectors were read from bench/heapGolden.txt");
    $display("tests %0d, failed %0d, mismatches %0d", testCount, failedTests, errorCount);
    if (errorCount == 0 && testCount > 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* design/heapAllocator.sv */
/*
  Heap allocator: per array allocation flags, a high-water count of
  numbers ever handed out and a LIFO of freed numbers for reuse
*/
module heapAllocator #(
  parameter int arrayBits = heapPkg::defaultArrayBits
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 allocRequest,
  input  logic                 freeRequest,
  input  logic                 clearAll,
  input  logic [arrayBits-1:0] queryArray,
  output logic                 queryAllocated,
  output logic                 queryEverUsed,
  output logic [arrayBits-1:0] grantArray,
  output logic                 grantValid
);

  typedef logic [arrayBits-1:0] arrayNumber;
  typedef logic [arrayBits:0]   arrayTally;   // Counts up to arrayCount

  localparam int arrayCount = 2 ** arrayBits;

  logic [arrayCount-1:0] allocated;
  arrayTally             highWater;            // Next fresh number
  arrayTally             freeTop;              // Freed numbers stacked
  arrayNumber            freeStack [arrayCount];
  logic                  stackEmpty;

  // ----------------------------------------
  // Next grant, recently freed first
  assign stackEmpty = freeTop == '0;
  assign grantValid = !stackEmpty || highWater < arrayTally'(arrayCount);
  assign grantArray = stackEmpty ? arrayNumber'(highWater)
                                 : freeStack[arrayNumber'(freeTop - 1'b1)];

  assign queryAllocated = allocated[queryArray];
  assign queryEverUsed  = arrayTally'(queryArray) < highWater;

  // ----------------------------------------
  // Flags and counters
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      highWater <= '0;
      freeTop   <= '0;
    end else if (clearAll) begin
      allocated <= '0;                         // Every number fresh again
      highWater <= '0;
      freeTop   <= '0;
    end else begin
      if (allocRequest) begin
        allocated[grantArray] <= 1'b1;
        if (stackEmpty)
          highWater <= highWater + 1'b1;
        else
          freeTop <= freeTop - 1'b1;          // Pop reused number
      end
      if (freeRequest) begin
        allocated[queryArray] <= 1'b0;
        freeTop               <= freeTop + 1'b1;
      end
    end
  end

  // Stack contents
  always_ff @(posedge clock) begin
    if (freeRequest)
      freeStack[arrayNumber'(freeTop)] <= queryArray;
  end

  allocOnlyWhenGrantable: assert property (@(posedge clock) disable iff (!resetN)
    allocRequest |-> grantValid);

  freeOnlyAllocated: assert property (@(posedge clock) disable iff (!resetN)
    freeRequest |-> allocated[queryArray]);

endmodule

/* design/heapArrayStore.sv */
/*
  Heap array store: every array as one fixed block of elements,
  with a size per array and a registered read port
*/
module heapArrayStore #(
  parameter int arrayBits = heapPkg::defaultArrayBits,
  parameter int indexBits = heapPkg::defaultIndexBits,
  parameter int dataBits  = heapPkg::defaultDataBits
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 storeRead,
  input  logic                 storeWrite,
  input  logic [arrayBits-1:0] storeArray,
  input  logic [indexBits-1:0] storeIndex,
  input  logic [dataBits-1:0]  storeData,
  input  logic                 sizeWrite,
  input  logic [indexBits:0]   sizeValue,
  output logic [dataBits-1:0]  elementOut,
  output logic [indexBits:0]   sizeOut
);

  typedef logic [indexBits:0]  elementSize;
  typedef logic [dataBits-1:0] elementData;

  localparam int arrayCount  = 2 ** arrayBits;
  localparam int arrayLength = 2 ** indexBits;

  elementData memory [arrayCount * arrayLength];  // Array n at n * arrayLength
  elementSize sizeTable [arrayCount];             // Live elements per array

  logic [arrayBits+indexBits-1:0] address;

  assign address = {storeArray, storeIndex};

  // ----------------------------------------
  // Element block and read register
  always_ff @(posedge clock) begin
    if (storeWrite)
      memory[address] <= storeData;
    if (storeRead) begin
      elementOut <= memory[address];     // Old value on a same cycle write
      sizeOut    <= sizeTable[storeArray];
    end
  end

  // ----------------------------------------
  // Size table
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < arrayCount; i++)
        sizeTable[i] <= '0;
    end else if (sizeWrite) begin
      sizeTable[storeArray] <= sizeValue;
    end
  end

  sizeWithinLength: assert property (@(posedge clock) disable iff (!resetN)
    sizeWrite |-> sizeValue <= elementSize'(arrayLength));

endmodule

/* design/heapController.sv */
/*
  Heap controller: APB register block plus the command FSM that
  checks each command, drives the store and allocator, and answers
*/
module heapController #(
  parameter int arrayBits = heapPkg::defaultArrayBits,
  parameter int indexBits = heapPkg::defaultIndexBits,
  parameter int dataBits  = heapPkg::defaultDataBits
) (
  input  logic                   clock,
  input  logic                   resetN,
  input  heapPkg::apbRequest     apb,
  output heapPkg::apbResponse    apbOut,
  output logic                   storeRead,
  output logic                   storeWrite,
  output logic [arrayBits-1:0]   storeArray,
  output logic [indexBits-1:0]   storeIndex,
  output logic [dataBits-1:0]    storeData,
  output logic                   sizeWrite,
  output logic [indexBits:0]     sizeValue,
  input  logic [dataBits-1:0]    elementOut,
  input  logic [indexBits:0]     sizeOut,
  output logic                   allocRequest,
  output logic                   freeRequest,
  output logic                   clearAll,
  output logic [arrayBits-1:0]   queryArray,
  input  logic                   queryAllocated,
  input  logic                   queryEverUsed,
  input  logic [arrayBits-1:0]   grantArray,
  input  logic                   grantValid,
  output heapPkg::heapCommand    aluCommand,
  output logic [dataBits-1:0]    aluOperand,
  input  logic [dataBits-1:0]    newValue
);
  import heapPkg::*;

  typedef logic [arrayBits-1:0] arrayNumber;
  typedef logic [indexBits-1:0] elementIndex;
  typedef logic [indexBits:0]   elementSize;
  typedef logic [dataBits-1:0]  elementData;

  localparam elementSize arrayLength = elementSize'(2 ** indexBits);

  typedef enum logic [1:0] {idle, fetch, execute, respond} controlState;

  controlState state;
  heapCommand  command;                   // Command being run
  arrayNumber  selArray;                  // regSelect fields
  elementIndex selIndex;
  elementData  operandReg;
  elementData  resultReg;
  heapError    statusError;
  heapError    liveError;                 // Array existence check
  heapError    execError;
  elementData  resultNext;
  apbWord      readData;
  logic        apbAccess, commandSetup, commandAccess;
  logic        arithCommand, execOk, growsSize;

  // ----------------------------------------
  // APB decode
  assign apbAccess     = apb.psel && apb.penable;
  assign commandSetup  = apb.psel && !apb.penable && apb.pwrite && apb.paddr == regCommand;
  assign commandAccess = apbAccess && apb.pwrite && apb.paddr == regCommand;

  always_comb begin
    case (apb.paddr)
      regSelect:  readData = (apbWord'(selArray) << 8) | apbWord'(selIndex);
      regOperand: readData = apbWord'(operandReg);
      regCommand: readData = apbWord'(command);
      regResult:  readData = apbWord'(resultReg);
      regStatus:  readData = apbWord'({state != idle, 4'b0000, statusError});
      default:    readData = '0;          // Unmapped
    endcase
  end

  // Command writes stall until respond, all else completes at once
  assign apbOut = '{
    prdata:  readData,
    pready:  apbAccess && (!commandAccess || state == respond),
    pslverr: commandAccess && state == respond && statusError != errNone
  };

  // ----------------------------------------
  // Legality checks, first failure wins
  assign arithCommand = command inside {cmdAdd, cmdAddAfter, cmdSubtract, cmdSubAfter,
                                        cmdShiftLeft, cmdShiftRight, cmdNotLogical,
                                        cmdNot, cmdOr, cmdXor, cmdAnd};
  assign liveError = !queryEverUsed  ? errNotAllocated :
                     !queryAllocated ? errFreed : errNone;
  assign growsSize = elementSize'(selIndex) >= sizeOut;

  always_comb begin
    execError = liveError;                // Default covers write, size, free
    case (command)
      cmdReset: execError = errNone;
      cmdAlloc: execError = grantValid ? errNone : errOutOfMemory;
      cmdWrite, cmdSize, cmdFree: ;
      cmdPush:
        if (liveError == errNone && sizeOut == arrayLength) execError = errFull;
      cmdPop:
        if (liveError == errNone && sizeOut == '0) execError = errEmpty;
      default:
        if (!(arithCommand || command == cmdRead)) execError = errBadCommand;
        else if (liveError == errNone && !(elementSize'(selIndex) < sizeOut))
          execError = errOutOfBounds;
    endcase
  end

  assign execOk = state == execute && execError == errNone;

  always_comb begin
    case (command)
      cmdWrite:                     resultNext = operandReg;
      cmdRead, cmdPop:              resultNext = elementOut;
      cmdAddAfter, cmdSubAfter:     resultNext = elementOut;  // Value before update
      cmdSize:                      resultNext = elementData'(sizeOut);
      cmdAlloc:                     resultNext = elementData'(grantArray);
      default: resultNext = arithCommand ? newValue : resultReg;
    endcase
  end

  // ----------------------------------------
  // Store, allocator and ALU drive
  assign storeRead  = (state == idle && commandSetup) || state == fetch;  // Size, then element
  assign storeArray = (state == execute && command == cmdAlloc) ? grantArray : selArray;

  always_comb begin
    if (state == fetch && apb.pwdata[7:0] == cmdPop)
      storeIndex = elementIndex'(sizeOut - 1'b1);       // Top element
    else if (state == execute && command == cmdPush)
      storeIndex = elementIndex'(sizeOut);              // First free slot
    else
      storeIndex = selIndex;
  end

  assign storeWrite = execOk && (command == cmdWrite || command == cmdPush || arithCommand);
  assign storeData  = (command == cmdWrite || command == cmdPush) ? operandReg : newValue;
  assign sizeWrite  = execOk && ((command == cmdWrite && growsSize) || command == cmdPush ||
                                 command == cmdPop || command == cmdAlloc);

  always_comb begin
    case (command)
      cmdWrite: sizeValue = elementSize'(selIndex) + 1'b1;
      cmdPush:  sizeValue = sizeOut + 1'b1;
      cmdPop:   sizeValue = sizeOut - 1'b1;
      default:  sizeValue = '0;           // Fresh array starts empty
    endcase
  end

  assign allocRequest = execOk && command == cmdAlloc;
  assign freeRequest  = execOk && command == cmdFree;
  assign clearAll     = execOk && command == cmdReset;
  assign queryArray   = selArray;
  assign aluCommand   = command;
  assign aluOperand   = operandReg;

  // ----------------------------------------
  // Registers and FSM
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state       <= idle;
      command     <= cmdReset;
      selArray    <= '0;
      selIndex    <= '0;
      operandReg  <= '0;
      resultReg   <= '0;
      statusError <= errNone;
    end else begin
      if (apbAccess && apb.pwrite && apb.paddr == regSelect) begin
        selArray <= apb.pwdata[8 +: arrayBits];
        selIndex <= apb.pwdata[0 +: indexBits];
      end
      if (apbAccess && apb.pwrite && apb.paddr == regOperand)
        operandReg <= apb.pwdata[dataBits-1:0];
      case (state)
        idle: if (commandSetup) state <= fetch;
        fetch: begin
          command <= heapCommand'(apb.pwdata[7:0]);
          state   <= execute;
        end
        execute: begin
          statusError <= execError;
          if (execOk) resultReg <= resultNext;
          state <= respond;
        end
        default: state <= idle;           // Respond, pready high this cycle
      endcase
    end
  end

  // Command write answers in its third access cycle, two after fetch
  commandReadyThird: assert property (@(posedge clock) disable iff (!resetN)
    commandAccess && apbOut.pready |-> $past(state, 2) == fetch);

  writeOnlyInExecute: assert property (@(posedge clock) disable iff (!resetN)
    storeWrite |-> $past(state) == fetch && queryAllocated);

endmodule

/* design/heapElementAlu.sv */
/*
  Heap element ALU: new value of one element for the arithmetic
  and logic commands, wrapped to the element width
*/
module heapElementAlu #(
  parameter int dataBits = heapPkg::defaultDataBits
) (
  input  heapPkg::heapCommand aluCommand,
  input  logic [dataBits-1:0] elementOut,
  input  logic [dataBits-1:0] aluOperand,
  output logic [dataBits-1:0] newValue
);
  import heapPkg::*;

  typedef logic [dataBits-1:0] elementData;

  elementData sum;                        // Shared by add forms
  elementData difference;                 // Shared by subtract forms

  assign sum        = elementOut + aluOperand;
  assign difference = elementOut - aluOperand;

  // ----------------------------------------
  // Operation select
  always_comb begin
    case (aluCommand)
      cmdAdd, cmdAddAfter:
        newValue = sum;
      cmdSubtract, cmdSubAfter:
        newValue = difference;
      cmdShiftLeft:
        newValue = elementOut << aluOperand;   // Amount from operand
      cmdShiftRight:
        newValue = elementOut >> aluOperand;
      cmdNotLogical:
        newValue = elementData'(elementOut == '0);  // One or zero
      cmdNot:
        newValue = ~elementOut;
      cmdOr:
        newValue = elementOut | aluOperand;
      cmdXor:
        newValue = elementOut ^ aluOperand;
      cmdAnd:
        newValue = elementOut & aluOperand;
      default:
        newValue = elementOut;            // Not an ALU command, keep value
    endcase
  end

endmodule

/* design/heapPkg.sv */
/*
  Heap package: command and error codes, APB request and response
  structs, register map and the default array geometry
*/
package heapPkg;

  // ----------------------------------------
  // Commands, numbered as on the host side
  typedef enum logic [7:0] {
    cmdReset      = 8'd1,                 // Forget all arrays
    cmdWrite      = 8'd2,
    cmdRead       = 8'd3,
    cmdSize       = 8'd4,
    cmdPush       = 8'd14,
    cmdPop        = 8'd15,
    cmdAlloc      = 8'd18,
    cmdFree       = 8'd19,
    cmdAdd        = 8'd20,                // Returns new value
    cmdAddAfter   = 8'd21,                // Returns previous value
    cmdSubtract   = 8'd22,
    cmdSubAfter   = 8'd23,
    cmdShiftLeft  = 8'd24,
    cmdShiftRight = 8'd25,
    cmdNotLogical = 8'd26,
    cmdNot        = 8'd27,                // Bitwise
    cmdOr         = 8'd28,
    cmdXor        = 8'd29,
    cmdAnd        = 8'd30
  } heapCommand;

  // Result of the legality checks
  typedef enum logic [3:0] {
    errNone,
    errNotAllocated,                      // Number never handed out
    errFreed,                             // Handed out, then freed
    errOutOfBounds,
    errFull,
    errEmpty,
    errOutOfMemory,
    errBadCommand
  } heapError;

  // ----------------------------------------
  // APB signals
  typedef logic [31:0] apbWord;

  typedef struct packed {
    logic   psel;
    logic   penable;
    logic   pwrite;
    apbWord paddr;
    apbWord pwdata;
  } apbRequest;

  typedef struct packed {
    apbWord prdata;
    logic   pready;
    logic   pslverr;
  } apbResponse;

  // Register map
  localparam apbWord regSelect  = 32'h00; // Array 15:8, index 7:0
  localparam apbWord regOperand = 32'h04;
  localparam apbWord regCommand = 32'h08; // Write starts a command
  localparam apbWord regResult  = 32'h0C;
  localparam apbWord regStatus  = 32'h10; // Error 3:0, busy 8

  // Geometry defaults
  localparam int defaultArrayBits = 2;
  localparam int defaultIndexBits = 3;
  localparam int defaultDataBits  = 12;

endpackage

/* design/heapTop.sv */
/*
  Heap top: APB slave around the controller, array store,
  allocator and element ALU, with the array geometry set here
*/
module heapTop #(
  parameter int arrayBits = heapPkg::defaultArrayBits,
  parameter int indexBits = heapPkg::defaultIndexBits,
  parameter int dataBits  = heapPkg::defaultDataBits
) (
  input  logic                clock,
  input  logic                resetN,
  input  heapPkg::apbRequest  apb,
  output heapPkg::apbResponse apbOut
);
  import heapPkg::*;

  typedef logic [arrayBits-1:0] arrayNumber;
  typedef logic [indexBits-1:0] elementIndex;
  typedef logic [indexBits:0]   elementSize;
  typedef logic [dataBits-1:0]  elementData;

  // ----------------------------------------
  // Interconnect
  logic        storeRead, storeWrite, sizeWrite;
  arrayNumber  storeArray;
  elementIndex storeIndex;
  elementData  storeData, elementOut;
  elementSize  sizeValue, sizeOut;
  logic        allocRequest, freeRequest, clearAll;
  arrayNumber  queryArray, grantArray;
  logic        queryAllocated, queryEverUsed, grantValid;
  heapCommand  aluCommand;
  elementData  aluOperand, newValue;

  heapController #(.arrayBits(arrayBits), .indexBits(indexBits), .dataBits(dataBits))
    controller (.*);                      // Registers and command FSM

  heapArrayStore #(.arrayBits(arrayBits), .indexBits(indexBits), .dataBits(dataBits))
    arrayStore (.clock, .resetN, .storeRead, .storeWrite, .storeArray, .storeIndex,
                .storeData, .sizeWrite, .sizeValue, .elementOut, .sizeOut);

  heapAllocator #(.arrayBits(arrayBits))
    allocator (.clock, .resetN, .allocRequest, .freeRequest, .clearAll, .queryArray,
               .queryAllocated, .queryEverUsed, .grantArray, .grantValid);

  heapElementAlu #(.dataBits(dataBits))
    elementAlu (.aluCommand, .elementOut, .aluOperand, .newValue);

endmodule

/* heapTop.f */
design/heapPkg.sv
design/heapElementAlu.sv
design/heapArrayStore.sv
design/heapAllocator.sv
design/heapController.sv
design/heapTop.sv
bench/heapTopTb.sv

/* runSim.sh */
#!/bin/sh
# Build the heap testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

logFile=heapSim.log

verilator --binary --timing --assert -Wno-fatal --top-module heapTopTb \
  -f heapTop.f -o heapSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/heapSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

grep -q -F "*** TEST PASSED ***" "$logFile"
if [ $? -ne 0 ]; then
  echo "Pass message not found in $logFile"
  exit 1
fi

exit 0
